/* uart_link.f */
src/uart_pkg.sv
src/byte_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_link.sv
dv/uart_link_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f uart_link.f --top-module uart_link_tb -Mdir obj_dir

out=$(./obj_dir/Vuart_link_tb)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1

/* dv/uart_link_tb.sv */
`timescale 1ns/1ns

module uart_link_tb import uart_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 40 * 10 * CLKS_PER_BIT + 2000;
    localparam int BURST_LEN      = 20;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic [7:0] in_data;
    logic       in_credit;
    logic       txd;
    logic       rxd;
    logic       out_credit;
    logic       out_valid;
    logic [7:0] out_data;
    logic       out_frame_err;
    logic       rx_overrun;

    logic       loopback;
    logic       tb_rxd;
    logic       rand_grant;
    logic [7:0] b;

    // expected words in delivery order
    logic [7:0] sb_data[$];
    logic       sb_err[$];

    int sent_total;
    int credit_total;
    int req_total;
    int req_served;
    int grants_total;
    int valids_total;
    int lost_credits;
    int check_errs;
    int cmp_errs;
    int err_base;
    int tests_run;
    int pulse_base;
    int rx_base;
    int cycles;

    assign rxd = loopback ? txd : tb_rxd;

    uart_link UUT (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_data(in_data), .in_credit(in_credit),
        .txd(txd), .rxd(rxd),
        .out_credit(out_credit), .out_valid(out_valid), .out_data(out_data),
        .out_frame_err(out_frame_err), .rx_overrun(rx_overrun)
    );

    // ==============================
    // reference and helpers
    // ==============================

    // line level of bit idx in a frame: start, 8 data LSB first, stop
    function automatic logic frame_bit(input logic [7:0] data, input int idx);
        if (idx == 0) begin
            return 1'b0;
        end else if (idx <= DATA_BITS) begin
            return data[3'(idx - 1)];
        end
        return 1'b1;
    endfunction

    task automatic expect_word(input logic [7:0] data, input logic err);
        sb_data.push_back(data);
        sb_err.push_back(err);
    endtask

    // host side, only sends while holding a credit
    task automatic send_byte(input logic [7:0] data);
        @(posedge clk);
        while (sent_total - credit_total >= FIFO_DEPTH) begin
            @(posedge clk);
        end
        in_valid   <= 1'b1;
        in_data    <= data;
        sent_total = sent_total + 1;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic stop);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            tb_rxd <= (i == 9) ? stop : frame_bit(data, i);
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        tb_rxd <= 1'b1;
        repeat (2 * CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic wait_rx(input int n);
        while (valids_total < n) begin
            @(posedge clk);
        end
    endtask

    // txd high for longer than any run inside a frame
    task automatic wait_line_idle();
        int quiet;
        quiet = 0;
        while (quiet < 12 * CLKS_PER_BIT) begin
            @(negedge clk);
            if (txd === 1'b1) begin
                quiet = quiet + 1;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // credits still held by the DUT vanish with the reset
        lost_credits = grants_total - valids_total;
        sent_total   = credit_total;
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        $display("test %0d %s: %0d errors", tests_run, name,
                 check_errs + cmp_errs - err_base);
        err_base = check_errs + cmp_errs;
    endtask

    // ==============================
    // clock, consumer, timeout
    // ==============================

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        out_credit <= 1'b0;
        forever begin
            @(posedge clk);
            if (req_served < req_total) begin
                out_credit <= 1'b1;
                req_served   = req_served + 1;
                grants_total = grants_total + 1;
            end else if (rand_grant && grants_total - valids_total - lost_credits < FIFO_DEPTH
                         && $urandom % 4 == 0) begin
                out_credit <= 1'b1;
                grants_total = grants_total + 1;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    // ==============================
    // scoreboard compare
    // ==============================

    always @(negedge clk) begin
        if (in_credit === 1'b1) begin
            credit_total = credit_total + 1;
        end
        if (out_valid === 1'b1) begin
            if (grants_total - valids_total - lost_credits <= 0) begin
                $display("out_valid fired without a granted credit");
                cmp_errs = cmp_errs + 1;
            end
            if (valids_total >= sb_data.size()) begin
                $display("out_valid fired with no byte expected");
                cmp_errs = cmp_errs + 1;
            end else begin
                if (out_data !== sb_data[valids_total]) begin
                    $display("FAILED out_data: got %h expected %h",
                             out_data, sb_data[valids_total]);
                    cmp_errs = cmp_errs + 1;
                end
                if (out_frame_err !== sb_err[valids_total]) begin
                    $display("FAILED out_frame_err: got %h expected %h",
                             out_frame_err, sb_err[valids_total]);
                    cmp_errs = cmp_errs + 1;
                end
            end
            valids_total = valids_total + 1;
        end
    end

    // ==============================
    // tests
    // ==============================

    initial begin
        void'($urandom(32'h0c80934e));
        rst        <= 1'b1;
        in_valid   <= 1'b0;
        in_data    <= 8'h00;
        tb_rxd     <= 1'b1;
        loopback   <= 1'b1;
        rand_grant <= 1'b0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (txd !== 1'b1) begin
            $display("FAILED txd: got %h expected 1", txd);
            check_errs = check_errs + 1;
        end
        if (in_credit !== 1'b0 || out_valid !== 1'b0 || rx_overrun !== 1'b0) begin
            $display("FAILED in_credit/out_valid/rx_overrun: got %h/%h/%h expected 0/0/0",
                     in_credit, out_valid, rx_overrun);
            check_errs = check_errs + 1;
        end
        end_test("reset_state");

        // single frame, txd sampled mid-bit from the falling edge
        b = 8'($urandom);
        pulse_base = credit_total;
        rx_base    = valids_total;
        expect_word(b, 1'b0);
        send_byte(b);
        while (txd !== 1'b0) begin
            @(negedge clk);
        end
        for (int i = 0; i < 10; i++) begin
            repeat ((i == 0) ? CLKS_PER_BIT / 2 : CLKS_PER_BIT) @(negedge clk);
            if (txd !== frame_bit(b, i)) begin
                $display("FAILED txd bit %0d: got %h expected %h", i, txd, frame_bit(b, i));
                check_errs = check_errs + 1;
            end
        end
        req_total = req_total + 1;
        wait_rx(rx_base + 1);
        if (credit_total - pulse_base != 1) begin
            $display("FAILED in_credit pulses: got %h expected 1", credit_total - pulse_base);
            check_errs = check_errs + 1;
        end
        end_test("frame_waveform");

        pulse_base = credit_total;
        rx_base    = valids_total;
        rand_grant <= 1'b1;
        for (int i = 0; i < BURST_LEN; i++) begin
            b = 8'($urandom);
            expect_word(b, 1'b0);
            send_byte(b);
        end
        wait_rx(rx_base + BURST_LEN);
        rand_grant <= 1'b0;
        if (credit_total - pulse_base != BURST_LEN) begin
            $display("FAILED in_credit pulses: got %h expected %h",
                     credit_total - pulse_base, BURST_LEN);
            check_errs = check_errs + 1;
        end
        end_test("loopback_burst");

        // no grants, last two frames overrun the receive queue
        apply_reset();
        rx_base = valids_total;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            b = 8'($urandom);
            if (i < FIFO_DEPTH) begin
                expect_word(b, 1'b0);
            end
            send_byte(b);
        end
        wait_line_idle();
        if (rx_overrun !== 1'b1) begin
            $display("FAILED rx_overrun: got %h expected 1", rx_overrun);
            check_errs = check_errs + 1;
        end
        req_total = req_total + FIFO_DEPTH;
        wait_rx(rx_base + FIFO_DEPTH);
        repeat (4 * CLKS_PER_BIT) @(posedge clk);
        if (valids_total != rx_base + FIFO_DEPTH) begin
            $display("more words delivered than credits granted");
            check_errs = check_errs + 1;
        end
        end_test("backpressure_overrun");

        loopback <= 1'b0;
        apply_reset();
        rx_base   = valids_total;
        req_total = req_total + 2;
        b = 8'($urandom);
        expect_word(b, 1'b1);
        drive_frame(b, 1'b0);
        wait_rx(rx_base + 1);
        b = 8'($urandom);
        expect_word(b, 1'b0);
        drive_frame(b, 1'b1);
        wait_rx(rx_base + 2);
        end_test("framing_error");

        $display("%0d tests run, %0d words checked, %0d errors",
                 tests_run, valids_total, check_errs + cmp_errs);
        if (check_errs + cmp_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/uart_link.sv */
`timescale 1ns/1ns

module uart_link import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  logic [7:0] in_data,
    output logic       in_credit,
    output logic       txd,
    input  logic       rxd,
    input  logic       out_credit,
    output logic       out_valid,
    output logic [7:0] out_data,
    output logic       out_frame_err,
    output logic       rx_overrun
);

    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_t;

    logic [7:0] tx_head;
    logic       tx_have;
    logic       tx_take;

    logic       rx_word_valid;
    rx_word_t   rx_word;
    rx_word_t   rx_head;
    logic       rx_push;
    logic       rx_not_empty;
    logic       rx_full;

    credit_t    credit_cnt;
    logic       send;

    // ==============================
    // transmit path
    // ==============================

    byte_fifo #(.T(logic [7:0]), .DEPTH(FIFO_DEPTH)) tx_queue (
        .clk(clk), .rst(rst),
        .push(in_valid), .wdata(in_data),
        .pop(tx_take), .rdata(tx_head),
        .not_empty(tx_have), .full()
    );

    uart_tx tx (
        .clk(clk), .rst(rst),
        .have_byte(tx_have), .byte_in(tx_head),
        .take(tx_take), .txd(txd)
    );

    // every pop hands one credit back to the host
    assign in_credit = tx_take;

    // ==============================
    // receive path
    // ==============================

    uart_rx rx (
        .clk(clk), .rst(rst), .rxd(rxd),
        .word_valid(rx_word_valid), .word(rx_word)
    );

    assign rx_push = rx_word_valid && !rx_full;

    byte_fifo #(.T(rx_word_t), .DEPTH(FIFO_DEPTH)) rx_queue (
        .clk(clk), .rst(rst),
        .push(rx_push), .wdata(rx_word),
        .pop(send), .rdata(rx_head),
        .not_empty(rx_not_empty), .full(rx_full)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_overrun <= 1'b0;
        end else if (rx_word_valid && rx_full) begin
            rx_overrun <= 1'b1;
        end
    end

    // one consumer credit spent per delivered word
    assign send = (credit_cnt != '0) && rx_not_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= '0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= send;
            if (out_credit && !send && credit_cnt != credit_t'(FIFO_DEPTH)) begin
                credit_cnt <= credit_cnt + 1'b1;
            end else if (send && !out_credit) begin
                credit_cnt <= credit_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_data      <= rx_head.data;
            out_frame_err <= rx_head.frame_err;
        end
    end

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rxd,
    output logic     word_valid,
    output rx_word_t word
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    typedef logic [$clog2(DATA_BITS)-1:0] idx_t;

    state_t               state;
    logic [BIT_CNT_W-1:0] baud_cnt;
    idx_t                 bit_idx;
    logic [DATA_BITS-1:0] shift_reg;

    logic rxd_meta;
    logic rxd_sync;
    logic rxd_prev;
    logic fall;
    logic half_end;
    logic bit_end;

    // ==============================
    // input synchronizer
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall     = rxd_prev && !rxd_sync;
    assign half_end = (baud_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end  = (baud_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    // ==============================
    // mid-bit sampling FSM
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            baud_cnt   <= baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    if (fall) begin
                        state <= START;
                    end
                end
                START: begin
                    // half a bit in, line must still be low
                    if (half_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rxd_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == idx_t'(DATA_BITS - 1)) begin
                            state <= STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        word_valid <= 1'b1;
                        state      <= IDLE;
                    end
                end
            endcase
        end
    end

    // received bits enter at the top, LSB ends up at [0]
    always_ff @(posedge clk) begin
        if (state == DATA && bit_end) begin
            shift_reg <= {rxd_sync, shift_reg[DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (state == STOP && bit_end) begin
            word.data      <= shift_reg;
            word.frame_err <= !rxd_sync;
        end
    end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       have_byte,
    input  logic [7:0] byte_in,
    output logic       take,
    output logic       txd
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    typedef logic [$clog2(DATA_BITS)-1:0] idx_t;

    state_t               state;
    logic [BIT_CNT_W-1:0] baud_cnt;
    logic                 bit_end;
    idx_t                 bit_idx;
    logic [7:0]           shift_reg;

    // pop straight out of the queue while idle
    assign take    = (state == IDLE) && have_byte;
    assign bit_end = (baud_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    // ==============================
    // baud counter
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            baud_cnt <= '0;
        end else if (state == IDLE || bit_end) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // ==============================
    // frame sequencing
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= START;
                        txd   <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state   <= DATA;
                        bit_idx <= '0;
                        txd     <= shift_reg[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == idx_t'(DATA_BITS - 1)) begin
                            state <= STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shift_reg[0];
                        end
                    end
                end
                default: begin
                    // stop bit already on the line
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // LSB first, next bit always at [0]
    always_ff @(posedge clk) begin
        if (take) begin
            shift_reg <= byte_in;
        end else if (bit_end && (state == START || state == DATA)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

/* src/byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,
    output logic not_empty,
    output logic full
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    T     mem [DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    logic push_ok;
    logic pop_ok;

    // push when full is dropped here
    assign push_ok = push && !full;
    assign pop_ok  = pop && not_empty;

    assign not_empty = (count != '0);
    assign full      = (count == cnt_t'(DEPTH));
    assign rdata     = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                if (wr_ptr == ptr_t'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop_ok) begin
                if (rd_ptr == ptr_t'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/uart_pkg.sv */
package uart_pkg;

    // ==============================
    // serial timing
    // ==============================

    // clock cycles per serial bit, kept short for simulation
    localparam int CLKS_PER_BIT = 16;

    // baud counter runs 0 .. CLKS_PER_BIT-1
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

    // data bits per frame, sent LSB first
    localparam int DATA_BITS = 8;

    // ==============================
    // queues and credits
    // ==============================

    // entries per queue, also the host credits after reset
    localparam int FIFO_DEPTH = 4;

    // one received byte plus its stop-bit status
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        // stop bit sampled low
        logic frame_err;
    } rx_word_t;

endpackage
